// ==== sources.f ====
+incdir+rtl
rtl/bank_ctl_pkg.sv
rtl/cmd_decode.sv
rtl/bank_timer.sv
rtl/cmd_execute.sv
rtl/cmd_result.sv
rtl/bank_ctl_top.sv
testbench/tb_bank_ctl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_bank_ctl -f sources.f -o tb_bank_ctl > build.log 2>&1 \
    && ./obj_dir/tb_bank_ctl > sim.log 2>&1
cat build.log
test -f sim.log && cat sim.log
grep -q "Test failures found" sim.log 2>/dev/null && { echo "FAIL"; exit 1; } \
    || { test -f sim.log && echo "PASS" || { echo "FAIL: build failed"; exit 1; }; }

// ==== testbench/tb_bank_ctl.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the bank timing controller, instance dut
// same-bank gaps must meet each window, a held command may add one cycle
// one Wishbone cycle at a time, stb held until ack or err
// random mix comes from $urandom, seeded once at the start
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "bank_ctl_params.svh"

module tb_bank_ctl import bank_ctl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD   = 100;
    localparam int N_RANDOM = 300;
    localparam int N_CMDS   = N_RANDOM + 60;    // random, directed and status reads
    localparam int MAX_WAIT = 4 * `T_RC;        // negedges per bus cycle
    localparam int BUS_OVH  = 6;                // handshake cycles around a window
    localparam longint LIMIT_NS = longint'(N_CMDS) * (`T_RC + BUS_OVH) * PERIOD
                                  + 200 * PERIOD;

    logic        ctl_clk;
    logic        ctl_reset_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic        adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic        err;
    mem_cmd_t    mem_cmd;
    int          cycle = 0;                 // rising edges since start

    // reference model, one entry per bank
    logic        m_open     [`NUM_BANKS];
    int          m_act_t    [`NUM_BANKS];   // cycle of last ACT
    int          m_col_t    [`NUM_BANKS];   // cycle of last column access
    logic        m_col_read [`NUM_BANKS];
    int          m_close_t  [`NUM_BANKS];   // cycle of last PCH/RDAP/WRAP
    logic [2:0]  m_close_op [`NUM_BANKS];
    int          m_count = 0;               // issued commands

    bank_ctl_top dut (.*);

    initial
    begin
        ctl_clk = 1'b0;
        forever #(PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    always @(posedge ctl_clk)
        cycle <= cycle + 1;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    initial
    begin
        #(LIMIT_NS);
        stop_on_error("watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////////////////////////
    // bus protocol, sampled on the rising edge
    //////////////////////////////////////////////////////////////////////
    a_ack_err: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n) !(ack && err))
        else stop_on_error("ack and err were high in the same cycle");
    a_mem_ack: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
                                mem_cmd.valid |-> (ack && we))
        else stop_on_error("memory command came without the ack of a write");
    a_mem_one: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
                                mem_cmd.valid |=> !mem_cmd.valid)
        else stop_on_error("memory command stayed valid for more than one cycle");
    a_ack_one: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n) ack |=> !ack)
        else stop_on_error("ack stayed high for more than one cycle");
    a_err_one: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n) err |=> !err)
        else stop_on_error("err stayed high for more than one cycle");

    // one Wishbone cycle, lat counts negedges from stb up to the response
    task automatic bus_cycle(input logic w, input logic a, input logic [31:0] data,
                             output logic got_ack, output logic [31:0] rdata,
                             output mem_cmd_t seen, output int t, output int lat);
        lat = 0;
        @(posedge ctl_clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= w;
        adr   <= a;
        dat_w <= data;
        do
        begin
            @(negedge ctl_clk);     // outputs settled here
            lat++;
            if (lat > MAX_WAIT)
                stop_on_error("no ack or err within the wait limit");
        end
        while (!ack && !err);
        got_ack = ack;
        rdata   = dat_r;
        seen    = mem_cmd;
        t       = cycle;
        @(posedge ctl_clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic check_gap(input string pair, input int gap, input int window);
        assert (gap >= window)
        else stop_on_error($sformatf("%s gap of %0d cycles is below the %0d cycle window",
                                     pair, gap, window));
    endtask

    function automatic int later_of(input int x, input int y);
        return (x > y) ? x : y;
    endfunction

    function automatic logic expect_legal(input logic [2:0] op, input int b);
        if (op == OP_ACT)
            return !m_open[b];
        return (op <= 3'd5) && m_open[b];   // codes 6 and 7 never legal
    endfunction

    function automatic int act_window(input logic [2:0] closed_by);
        if (closed_by == OP_RDAP)
            return `T_RDAP_ACT;
        if (closed_by == OP_WRAP)
            return `T_WRAP_ACT;
        return `T_RP;
    endfunction

    task automatic close_bank(input int b, input int t, input logic [2:0] op);
        m_open[b]     = 1'b0;
        m_close_t[b]  = t;
        m_close_op[b] = op;
    endtask

    //////////////////////////////////////////////////////////////////////
    // one bank command, checked against the model, model updated
    //////////////////////////////////////////////////////////////////////
    task automatic send_cmd(input logic [2:0] op, input int b, input logic [`ROW_WIDTH-1:0] row);
        logic        legal;
        logic        got_ack;
        logic [31:0] rdata;
        mem_cmd_t    seen;
        mem_cmd_t    exp_cmd;
        int          t;
        int          lat;
        int          earliest;      // first cycle all windows allow
        legal   = expect_legal(op, b);
        exp_cmd = {1'b1, op, `BANK_WIDTH'(b), row};
        bus_cycle(1'b1, 1'b0, {2'b00, row, 10'd0, `BANK_WIDTH'(b), 1'b0, op},
                  got_ack, rdata, seen, t, lat);
        assert (got_ack == legal)
        else stop_on_error($sformatf("Fail ack: got %0h, expected %0h (op %0h bank %0h)",
                                     got_ack, legal, op, b));
        if (!legal)
        begin
            assert (!seen.valid)
            else stop_on_error($sformatf("Fail mem_cmd.valid: got %0h, expected 0", seen.valid));
            assert (lat == 3)       // err one cycle after cmd_valid
            else stop_on_error($sformatf("err came %0d cycles after stb instead of 3", lat));
        end
        else
        begin
            assert (seen == exp_cmd)
            else stop_on_error($sformatf("Fail mem_cmd: got %0h, expected %0h", seen, exp_cmd));
            case (op)
                OP_ACT:
                begin
                    check_gap("ACT to ACT", t - m_act_t[b], `T_RC);
                    check_gap("precharge to ACT", t - m_close_t[b], act_window(m_close_op[b]));
                    earliest   = later_of(m_act_t[b] + `T_RC,
                                          m_close_t[b] + act_window(m_close_op[b]));
                    m_open[b]  = 1'b1;
                    m_act_t[b] = t;
                end
                OP_PCH:
                begin
                    check_gap("ACT to PCH", t - m_act_t[b], `T_RAS);
                    earliest = m_act_t[b] + `T_RAS;
                    if (m_col_t[b] > m_act_t[b])    // column access in this open period
                    begin
                        check_gap(m_col_read[b] ? "RD to PCH" : "WR to PCH", t - m_col_t[b],
                                  m_col_read[b] ? `T_RTP : `T_WTP);
                        earliest = later_of(earliest,
                                            m_col_t[b] + (m_col_read[b] ? `T_RTP : `T_WTP));
                    end
                    close_bank(b, t, op);
                end
                default:
                begin
                    check_gap("ACT to RD/WR", t - m_act_t[b], `T_RCD);
                    earliest      = m_act_t[b] + `T_RCD;
                    m_col_t[b]    = t;
                    m_col_read[b] = (op == OP_RD) || (op == OP_RDAP);
                    if (op == OP_RDAP || op == OP_WRAP)
                        close_bank(b, t, op);
                end
            endcase
            // a held command goes out at most one cycle after its last window
            assert (lat <= 3 || t <= earliest + 1)
            else stop_on_error($sformatf("command held %0d cycles past its window",
                                         t - earliest));
            m_count++;
        end
    endtask

    task automatic check_status();
        logic                  got_ack;
        logic [31:0]           rdata;
        logic [31:0]           exp_word;
        logic [`NUM_BANKS-1:0] mask;
        mem_cmd_t              seen;
        int                    t;
        int                    lat;
        for (int i = 0; i < `NUM_BANKS; i++)
            mask[i] = m_open[i];
        exp_word = {m_count[15:0], {(16 - `NUM_BANKS){1'b0}}, mask};
        bus_cycle(1'b0, 1'b1, 32'd0, got_ack, rdata, seen, t, lat);
        assert (got_ack && lat == 2)    // acked one cycle after stb
        else stop_on_error($sformatf("status read answered badly after %0d cycles", lat));
        assert (rdata == exp_word)
        else stop_on_error($sformatf("Fail dat_r: got %0h, expected %0h", rdata, exp_word));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        int                    b;
        int                    pick;
        logic [2:0]            op;
        logic [`ROW_WIDTH-1:0] row;
        void'($urandom(54));
        ctl_reset_n = 1'b0;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = 1'b0;
        dat_w       = 32'd0;
        for (int i = 0; i < `NUM_BANKS; i++)
        begin
            m_open[i]     = 1'b0;
            m_act_t[i]    = -1000;      // far in the past
            m_col_t[i]    = -1000;
            m_col_read[i] = 1'b0;
            m_close_t[i]  = -1000;
            m_close_op[i] = OP_PCH;
        end
        repeat (3) @(posedge ctl_clk);
        ctl_reset_n <= 1'b1;
        @(negedge ctl_clk);
        assert (!ack && !err && !mem_cmd.valid)
        else stop_on_error($sformatf("Fail ack/err/mem_cmd.valid after reset: %0h %0h %0h",
                                     ack, err, mem_cmd.valid));
        check_status();

        // back-to-back on bank 0, each command as early as the bus allows
        send_cmd(OP_ACT,  0, 14'h0123);
        send_cmd(OP_RD,   0, 14'h0123);
        send_cmd(OP_PCH,  0, 14'h0000);
        send_cmd(OP_ACT,  0, 14'h2a5c);
        send_cmd(OP_WR,   0, 14'h2a5c);
        send_cmd(OP_PCH,  0, 14'h0000);
        send_cmd(OP_ACT,  0, 14'h3fff);
        send_cmd(OP_RDAP, 0, 14'h3fff);
        send_cmd(OP_ACT,  0, 14'h1001);
        send_cmd(OP_WRAP, 0, 14'h1001);
        send_cmd(OP_ACT,  0, 14'h0777);
        send_cmd(OP_PCH,  0, 14'h0000);     // tRAS right after ACT
        send_cmd(OP_ACT,  2, 14'h0042);

        // illegal commands leave the model as it was
        send_cmd(OP_ACT, 2, 14'h0042);      // bank already open
        send_cmd(OP_RD,  1, 14'h0010);      // bank idle
        send_cmd(3'd6,   2, 14'h0001);
        send_cmd(3'd7,   3, 14'h0002);
        check_status();

        for (int n = 0; n < N_RANDOM; n++)
        begin
            b    = int'($urandom_range(`NUM_BANKS - 1, 0));
            row  = `ROW_WIDTH'($urandom);
            pick = int'($urandom_range(9, 0));
            if (pick == 0)
                op = 3'($urandom_range(7, 6));      // undefined opcodes
            else if (pick == 1)
                op = 3'($urandom_range(5, 0));      // may not suit the bank state
            else if (m_open[b])
                op = 3'($urandom_range(5, 1));
            else
                op = OP_ACT;
            send_cmd(op, b, row);
            if (n % 25 == 24)
                check_status();
        end
        check_status();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/bank_ctl_top.sv ====
//////////////////////////////////////////////////////////////////////
// DDR bank timing controller, Wishbone classic in, bank commands out
// no refresh, data path or inter-bank timing
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "bank_ctl_params.svh"

module bank_ctl_top import bank_ctl_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_reset_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic        adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    output logic        err,
    output mem_cmd_t    mem_cmd
);

    logic                         cmd_valid;
    bank_cmd_t                    cmd;
    logic                         issue_valid;
    bank_cmd_t                    issue_cmd;
    logic                         reject;
    bank_ready_t [`NUM_BANKS-1:0] ready;
    logic [`NUM_BANKS-1:0]        open_mask;
    logic                         res_ack;
    logic                         res_err;
    logic [15:0]                  issued_count;

    cmd_decode u_decode
    (
        .ctl_clk      (ctl_clk),
        .ctl_reset_n  (ctl_reset_n),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .err          (err),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .res_ack      (res_ack),
        .res_err      (res_err),
        .open_mask    (open_mask),
        .issued_count (issued_count)
    );

    //////////////////////////////////////////////////////////////////////
    // one timer per bank, strobes decoded from the shared issue
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `NUM_BANKS; i++)
    begin : g_bank
        logic hit;      // issue addressed to this bank

        assign hit = issue_valid && (issue_cmd.bank == `BANK_WIDTH'(i));

        bank_timer u_timer
        (
            .ctl_clk     (ctl_clk),
            .ctl_reset_n (ctl_reset_n),
            .open        (hit && issue_cmd.op == OP_ACT),
            .close       (hit && (issue_cmd.op == OP_PCH || issue_cmd.op == OP_RDAP
                                  || issue_cmd.op == OP_WRAP)),
            .read        (hit && (issue_cmd.op == OP_RD || issue_cmd.op == OP_RDAP)),
            .write       (hit && (issue_cmd.op == OP_WR || issue_cmd.op == OP_WRAP)),
            .ready       (ready[i])
        );

        assign open_mask[i] = ready[i].is_open;
    end

    cmd_execute u_execute
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .ready       (ready),
        .cmd_done    (),
        .issue_valid (issue_valid),
        .issue_cmd   (issue_cmd),
        .reject      (reject)
    );

    cmd_result u_result
    (
        .ctl_clk      (ctl_clk),
        .ctl_reset_n  (ctl_reset_n),
        .issue_valid  (issue_valid),
        .issue_cmd    (issue_cmd),
        .reject       (reject),
        .mem_cmd      (mem_cmd),
        .res_ack      (res_ack),
        .res_err      (res_err),
        .issued_count (issued_count)
    );

endmodule

`default_nettype wire

// ==== rtl/cmd_result.sv ====
//////////////////////////////////////////////////////////////////////
// memory command register, bus response and issued count
// ack and mem_cmd.valid come from the same flop
// issued count wraps at 16 bits
//////////////////////////////////////////////////////////////////////
`default_nettype none

module cmd_result import bank_ctl_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_reset_n,
    input  logic        issue_valid,
    input  bank_cmd_t   issue_cmd,
    input  logic        reject,
    output mem_cmd_t    mem_cmd,
    output logic        res_ack,
    output logic        res_err,
    output logic [15:0] issued_count
);

    logic      issued_q;       // one cycle after issue
    bank_cmd_t mem_payload;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            issued_q     <= 1'b0;
            res_err      <= 1'b0;
            issued_count <= 16'd0;
        end
        else
        begin
            issued_q <= issue_valid;
            res_err  <= reject;
            if (issue_valid)
                issued_count <= issued_count + 16'd1;
        end
    end

    always_ff @(posedge ctl_clk)
    begin
        if (issue_valid)
            mem_payload <= issue_cmd;   // held until the next issue
    end

    assign res_ack      = issued_q;
    assign mem_cmd.valid = issued_q;
    assign mem_cmd.op   = mem_payload.op;
    assign mem_cmd.bank = mem_payload.bank;
    assign mem_cmd.row  = mem_payload.row;

endmodule

`default_nettype wire

// ==== rtl/cmd_execute.sv ====
//////////////////////////////////////////////////////////////////////
// checks a held command against its bank and issues it when ready
// cmd must stay steady while cmd_valid is high
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "bank_ctl_params.svh"

module cmd_execute import bank_ctl_pkg::*;
(
    input  logic                         ctl_clk,
    input  logic                         ctl_reset_n,
    input  logic                         cmd_valid,
    input  bank_cmd_t                    cmd,
    input  bank_ready_t [`NUM_BANKS-1:0] ready,
    output logic                         cmd_done,     // issue or reject
    output logic                         issue_valid,
    output bank_cmd_t                    issue_cmd,
    output logic                         reject
);

    bank_ready_t sel;       // addressed bank
    logic        legal;
    logic        timing_ok;
    logic        done;      // this command already answered

    assign sel = ready[cmd.bank];

    // legality from bank state, then the ready bit that applies
    always_comb
    begin
        legal     = 1'b0;
        timing_ok = 1'b0;
        case (cmd.op)
            OP_ACT:
            begin
                legal     = !sel.is_open;
                timing_ok = sel.act_ready;
            end
            OP_RD, OP_WR, OP_RDAP, OP_WRAP:
            begin
                legal     = sel.is_open;
                timing_ok = sel.rdwr_ready;
            end
            OP_PCH:
            begin
                legal     = sel.is_open;
                timing_ok = sel.pch_ready;
            end
            default:
            begin
                legal     = 1'b0;   // codes 6 and 7
                timing_ok = 1'b0;
            end
        endcase
    end

    assign issue_valid = cmd_valid && !done && legal && timing_ok;
    assign reject      = cmd_valid && !done && !legal;
    assign cmd_done    = issue_valid || reject;
    assign issue_cmd   = cmd;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
            done <= 1'b0;
        else if (!cmd_valid)
            done <= 1'b0;           // decoder dropped it, ready for the next
        else if (cmd_done)
            done <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/bank_timer.sv ====
//////////////////////////////////////////////////////////////////////
// per-bank open state and same-bank timing windows
// ready bits are registered, so each adds up to one cycle of slack
// open/close/read/write are single-cycle strobes, never open with close
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "bank_ctl_params.svh"

module bank_timer import bank_ctl_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_reset_n,
    input  logic        open,       // ACT to this bank
    input  logic        close,      // PCH, RDAP or WRAP
    input  logic        read,       // RD or RDAP
    input  logic        write,      // WR or WRAP
    output bank_ready_t ready
);

    localparam int CNT_W = 6;      // counts to 63

    localparam logic [CNT_W-1:0] PRELOAD = CNT_W'(`TIMER_OFFSET);
    localparam logic [CNT_W-1:0] W_RCD   = CNT_W'(`T_RCD);
    localparam logic [CNT_W-1:0] W_RC    = CNT_W'(`T_RC);
    localparam logic [CNT_W-1:0] W_RAS   = CNT_W'(`T_RAS);
    localparam logic [CNT_W-1:0] W_RTP   = CNT_W'(`T_RTP);
    localparam logic [CNT_W-1:0] W_WTP   = CNT_W'(`T_WTP);
    localparam logic [CNT_W-1:0] W_RP    = CNT_W'(`T_RP);
    localparam logic [CNT_W-1:0] W_RDAP  = CNT_W'(`T_RDAP_ACT);
    localparam logic [CNT_W-1:0] W_WRAP  = CNT_W'(`T_WRAP_ACT);

    // a one-cycle tRCD cannot wait for the counter
    localparam bit RCD_ON_OPEN = (`T_RCD < 2);

    logic [CNT_W-1:0] act_cnt;     // cycles since ACT
    logic [CNT_W-1:0] gen_cnt;     // cycles since RD/WR/close
    logic             is_open;
    logic             doing_read;  // last column access was a read
    logic             doing_ap;    // closed by auto precharge
    logic             doing_pch;   // closed by plain PCH
    logic             rdwr_rdy;
    logic             act_act_rdy; // tRC met
    logic             act_pch_rdy; // tRAS met
    logic             valid_rdy;   // column or precharge window met

    //////////////////////////////////////////////////////////////////////
    // counters and command history
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            act_cnt    <= '1;          // saturated, nothing pending
            gen_cnt    <= '1;
            is_open    <= 1'b0;
            doing_read <= 1'b0;
            doing_ap   <= 1'b0;
            doing_pch  <= 1'b0;
        end
        else
        begin
            if (open)
                act_cnt <= PRELOAD;
            else if (act_cnt != '1)
                act_cnt <= act_cnt + 1'b1;

            if (read || write || close)
                gen_cnt <= PRELOAD;
            else if (gen_cnt != '1)
                gen_cnt <= gen_cnt + 1'b1;

            if (open)
                is_open <= 1'b1;
            else if (close)
                is_open <= 1'b0;

            if (write)
                doing_read <= 1'b0;
            else if (read)
                doing_read <= 1'b1;

            if (close)
            begin
                doing_ap  <= read || write;     // RDAP or WRAP
                doing_pch <= !(read || write);
            end
            else if (open)
            begin
                doing_ap  <= 1'b0;
                doing_pch <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered windows
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            rdwr_rdy    <= 1'b0;
            act_act_rdy <= 1'b1;
            act_pch_rdy <= 1'b0;
            valid_rdy   <= 1'b1;
        end
        else
        begin
            if (close)
                rdwr_rdy <= 1'b0;
            else if (open && RCD_ON_OPEN)
                rdwr_rdy <= 1'b1;
            else
                rdwr_rdy <= is_open && (act_cnt >= W_RCD);

            act_act_rdy <= !open && (act_cnt >= W_RC);
            act_pch_rdy <= !open && (act_cnt >= W_RAS);

            if (read || write || close)
                valid_rdy <= 1'b0;     // new window starts now
            else if (doing_pch)
                valid_rdy <= gen_cnt >= W_RP;
            else if (doing_ap)
                valid_rdy <= gen_cnt >= (doing_read ? W_RDAP : W_WRAP);
            else
                valid_rdy <= gen_cnt >= (doing_read ? W_RTP : W_WTP);
        end
    end

    always_comb
    begin
        ready.is_open    = is_open;
        ready.act_ready  = act_act_rdy && valid_rdy;
        ready.rdwr_ready = rdwr_rdy;
        ready.pch_ready  = is_open && act_pch_rdy && valid_rdy;   // low while idle
    end

endmodule

`default_nettype wire

// ==== rtl/cmd_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone classic slave, one cycle in flight
// write to adr 0 is a bank command, read of adr 1 is status
// a write to adr 1 is turned into an illegal opcode and gets err
// master must hold cyc/stb until ack or err and drop stb after
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "bank_ctl_params.svh"

module cmd_decode import bank_ctl_pkg::*;
(
    input  logic                  ctl_clk,
    input  logic                  ctl_reset_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic                  adr,
    input  logic [31:0]           dat_w,
    output logic [31:0]           dat_r,
    output logic                  ack,
    output logic                  err,
    output logic                  cmd_valid,
    output bank_cmd_t             cmd,
    input  logic                  res_ack,          // command issued
    input  logic                  res_err,          // command rejected
    input  logic [`NUM_BANKS-1:0] open_mask,
    input  logic [15:0]           issued_count
);

    logic busy;      // cycle taken, waiting for stb to fall
    logic rd_ack;
    logic take;

    assign take = cyc && stb && !busy && !cmd_valid;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            busy      <= 1'b0;
            cmd_valid <= 1'b0;
            rd_ack    <= 1'b0;
        end
        else
        begin
            if (take)
                busy <= 1'b1;
            else if (!(cyc && stb))
                busy <= 1'b0;       // master ended the cycle

            if (take && we)
                cmd_valid <= 1'b1;
            else if (res_ack || res_err)
                cmd_valid <= 1'b0;

            rd_ack <= take && !we;  // status answers in one cycle
        end
    end

    // held command and status word
    always_ff @(posedge ctl_clk)
    begin
        if (take && we)
        begin
            cmd.op   <= adr ? cmd_op_t'(3'd7) : cmd_op_t'(dat_w[2:0]);
            cmd.bank <= dat_w[5:4];
            cmd.row  <= dat_w[29:16];
        end
        if (take && !we)
            dat_r <= adr ? {issued_count, {(16 - `NUM_BANKS){1'b0}}, open_mask} : 32'h0;
    end

    assign ack = res_ack || rd_ack;
    assign err = res_err;

endmodule

`default_nettype wire

// ==== rtl/bank_ctl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the bank timing controller
// field widths come from the params header
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "bank_ctl_params.svh"

package bank_ctl_pkg;

    // opcodes as written in dat_w[2:0], codes 6 and 7 are rejected
    typedef enum logic [2:0] {
        OP_ACT  = 3'd0,
        OP_RD   = 3'd1,
        OP_WR   = 3'd2,
        OP_RDAP = 3'd3,      // read, then auto precharge
        OP_WRAP = 3'd4,      // write, then auto precharge
        OP_PCH  = 3'd5
    } cmd_op_t;

    // one bank command, 19 bits
    typedef struct packed {
        cmd_op_t                op;
        logic [`BANK_WIDTH-1:0] bank;
        logic [`ROW_WIDTH-1:0]  row;
    } bank_cmd_t;

    typedef struct packed {
        logic                   valid;  // high for exactly one cycle per command
        cmd_op_t                op;
        logic [`BANK_WIDTH-1:0] bank;
        logic [`ROW_WIDTH-1:0]  row;
    } mem_cmd_t;

    // per-bank status from its timer
    typedef struct packed {
        logic is_open;
        logic act_ready;
        logic rdwr_ready;
        logic pch_ready;
    } bank_ready_t;

endpackage

`default_nettype wire

// ==== rtl/bank_ctl_params.svh ====
//////////////////////////////////////////////////////////////////////
// timing windows are counted in ctl_clk cycles and apply per bank
// no inter-bank windows such as tRRD or tFAW are tracked
// every window must stay below 63, the bank timer saturates there
//////////////////////////////////////////////////////////////////////
`ifndef BANK_CTL_PARAMS_SVH
`define BANK_CTL_PARAMS_SVH

// geometry
`define NUM_BANKS    4       // one bank timer each
`define BANK_WIDTH   2       // wide enough to index NUM_BANKS
`define ROW_WIDTH    14

// same-bank command windows
`define T_RCD        3       // ACT to RD/WR
`define T_RC         10      // ACT to ACT
`define T_RAS        7       // ACT to PCH
`define T_RTP        2       // RD to PCH
`define T_WTP        5       // WR to PCH, includes write recovery
`define T_RP         3       // PCH to ACT
`define T_RDAP_ACT   5       // RDAP to ACT
`define T_WRAP_ACT   8       // WRAP to ACT

`define TIMER_OFFSET 1       // counter preload, hides the registered ready

`endif
